// ==== include/shift_unit_cfg.svh ====
// Shift unit build configuration, command queue sizing
`ifndef SHIFT_UNIT_CFG_SVH
`define SHIFT_UNIT_CFG_SVH

// Number of command entries held ahead of the shift stage
// Must be a power of two so the ring pointers wrap on their own
`define SHIFT_QUEUE_DEPTH 4

// Index width of the queue, log2 of the depth
// Keep in step with SHIFT_QUEUE_DEPTH when resizing
`define SHIFT_QUEUE_AW 2

// Occupancy counter needs one extra bit to tell full from empty
// (derived in the queue as SHIFT_QUEUE_AW + 1)

// With the stage register behind it, the unit buffers
// SHIFT_QUEUE_DEPTH + 1 commands before cmd_ready drops

`endif

// ==== logic/shift_unit_pkg.sv ====
// Shift unit shared types for data words, op encoding and port structs
package shift_unit_pkg;

  // Operand and result word
  typedef logic [31:0] shift_word_t;

  // Shift distance from 0 to 31
  typedef logic [4:0] shift_amt_t;

  // Operation select
  typedef enum logic [1:0] {
    SHIFT_LSR  = 2'b00,  // Logical right
    SHIFT_ASR  = 2'b01,  // Arithmetic right
    SHIFT_ROR  = 2'b10,  // Rotate right
    SHIFT_SWAP = 2'b11   // Swap upper and lower halfwords
  } shift_op_e;

  // Command word of 39 bits
  typedef struct packed {
    shift_word_t operand;
    shift_amt_t  amount;
    shift_op_e   op;
  } shift_cmd_t;

  // Response word of 34 bits
  // carry is the last bit shifted out and 0 for swap or amount 0
  typedef struct packed {
    shift_word_t result;
    logic        zero;   // Result is all zeros
    logic        carry;  // Last bit shifted out
  } shift_rsp_t;

  // Bit counts of the port structs
  // Handy when packing into wider buses
  localparam int SHIFT_CMD_W = $bits(shift_cmd_t);
  localparam int SHIFT_RSP_W = $bits(shift_rsp_t);

endpackage

// ==== logic/shift_cmd_queue.sv ====
// Command queue, first-word-fall-through ring buffer with occupancy count
`include "shift_unit_cfg.svh"

module shift_cmd_queue (
  input  logic                       clk,
  input  logic                       rst_n,
  input  shift_unit_pkg::shift_cmd_t in_cmd,
  input  logic                       in_valid,
  output logic                       in_ready,
  output shift_unit_pkg::shift_cmd_t out_cmd,
  output logic                       out_valid,
  input  logic                       out_ready
);
  import shift_unit_pkg::*;

  localparam int DEPTH = `SHIFT_QUEUE_DEPTH;
  localparam int AW    = `SHIFT_QUEUE_AW;

  // Count value that marks a full buffer
  localparam logic [AW:0] DEPTH_CNT = (AW + 1)'(DEPTH);

  shift_cmd_t    mem [DEPTH];  // Entry storage
  logic [AW-1:0] wr_ptr;
  logic [AW-1:0] rd_ptr;
  logic [AW:0]   count;        // Entries held
  logic          full;
  logic          empty;
  logic          push;
  logic          pop;

  assign full  = (count == DEPTH_CNT);
  assign empty = (count == '0);

  // A full queue still takes a word when the head leaves in the same cycle
  assign in_ready = !full || out_ready;
  assign push     = in_valid && in_ready;

  // Head entry is visible without a read cycle
  assign out_valid = !empty;
  assign out_cmd   = mem[rd_ptr];
  assign pop       = out_valid && out_ready;

  // Storage write
  always_ff @(posedge clk) begin
    if (push) begin
      mem[wr_ptr] <= in_cmd;
    end
  end

  // Pointers wrap naturally, depth is a power of two
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
    end else begin
      if (push) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
    end
  end

  // Occupancy
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      count <= '0;
    end else begin
      case ({push, pop})
        2'b10:   count <= count + 1'b1;  // Write only
        2'b01:   count <= count - 1'b1;  // Read only
        default: count <= count;         // Idle or pass through
      endcase
    end
  end

endmodule

// ==== logic/shift_stage.sv ====
// Shift stage, computes result and flags and holds them under back-pressure
module shift_stage (
  input  logic                       clk,
  input  logic                       rst_n,
  input  shift_unit_pkg::shift_cmd_t cmd,
  input  logic                       cmd_valid,
  output logic                       cmd_ready,
  output shift_unit_pkg::shift_rsp_t rsp,
  output logic                       rsp_valid,
  input  logic                       rsp_ready
);
  import shift_unit_pkg::*;

  logic        accept;      // Command taken this cycle
  logic        rsp_taken;   // Response leaves this cycle
  logic [63:0] rot_wide;    // Doubled operand for rotate
  shift_word_t next_result;
  shift_amt_t  carry_idx;   // Position of the last bit shifted out
  logic        carry_live;  // Op and amount produce a carry
  logic        next_carry;
  logic        next_zero;
  shift_rsp_t  next_rsp;

  assign rsp_taken = rsp_valid && rsp_ready;

  // Stage can take a new command when empty or being drained
  assign cmd_ready = !rsp_valid || rsp_ready;
  assign accept    = cmd_valid && cmd_ready;

  // Rotate as a right shift of the operand concatenated with itself
  assign rot_wide = {cmd.operand, cmd.operand} >> cmd.amount;

  // Result word
  always_comb begin
    case (cmd.op)
      SHIFT_LSR:  next_result = cmd.operand >> cmd.amount;
      SHIFT_ASR:  next_result = $signed(cmd.operand) >>> cmd.amount;
      SHIFT_ROR:  next_result = rot_wide[31:0];
      SHIFT_SWAP: next_result = {cmd.operand[15:0], cmd.operand[31:16]};
      default:    next_result = cmd.operand;
    endcase
  end

  // Carry, same bit position for all three shift kinds
  assign carry_idx  = cmd.amount - 1'b1;
  assign carry_live = (cmd.op != SHIFT_SWAP) && (cmd.amount != '0);
  assign next_carry = carry_live ? cmd.operand[carry_idx] : 1'b0;

  assign next_zero = (next_result == '0);

  always_comb begin
    next_rsp.result = next_result;
    next_rsp.zero   = next_zero;
    next_rsp.carry  = next_carry;
  end

  // Payload only changes on accept, so it holds while stalled
  always_ff @(posedge clk) begin
    if (accept) begin
      rsp <= next_rsp;
    end
  end

  // Stage occupancy
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      rsp_valid <= 1'b0;
    end else if (accept) begin
      rsp_valid <= 1'b1;  // Refill, also covers drain and refill together
    end else if (rsp_taken) begin
      rsp_valid <= 1'b0;
    end
  end

endmodule

// ==== logic/shift_unit_top.sv ====
// Shift unit top level, command queue feeding the registered shift stage
module shift_unit_top (
  input  logic                       clk,
  input  logic                       rst_n,
  input  shift_unit_pkg::shift_cmd_t cmd,
  input  logic                       cmd_valid,
  output logic                       cmd_ready,
  output shift_unit_pkg::shift_rsp_t rsp,
  output logic                       rsp_valid,
  input  logic                       rsp_ready
);
  import shift_unit_pkg::*;

  // Queue head to stage
  shift_cmd_t q_cmd;
  logic       q_valid;
  logic       q_ready;

  // Buffers commands while the stage is stalled
  shift_cmd_queue u_queue (
    .clk       (clk),
    .rst_n     (rst_n),
    .in_cmd    (cmd),
    .in_valid  (cmd_valid),
    .in_ready  (cmd_ready),
    .out_cmd   (q_cmd),
    .out_valid (q_valid),
    .out_ready (q_ready)
  );

  // One cycle after the queue, result registered here
  shift_stage u_stage (
    .clk       (clk),
    .rst_n     (rst_n),
    .cmd       (q_cmd),
    .cmd_valid (q_valid),
    .cmd_ready (q_ready),
    .rsp       (rsp),
    .rsp_valid (rsp_valid),
    .rsp_ready (rsp_ready)
  );

endmodule

// ==== bench/shift_unit_clock.sv ====
// Testbench clock source, free-running clock with a 100 ns period
module shift_unit_clock (
  output logic clk
);
  timeunit 1ns;
  timeprecision 100ps;

  localparam int HALF_PERIOD = 50;  // ns

  initial begin
    clk = 1'b0;
    forever begin
      #HALF_PERIOD clk = ~clk;
    end
  end

endmodule

// ==== bench/shift_unit_tb.sv ====
// Shift unit testbench with directed, random and back-pressure checks against a reference model
`include "shift_unit_cfg.svh"

module shift_unit_tb;
  timeunit 1ns;
  timeprecision 100ps;
  import shift_unit_pkg::*;

  typedef enum logic [1:0] {BP_OPEN, BP_RANDOM, BP_STALL} bp_mode_e;

  localparam logic [31:0] SEED = 32'hc042_8ccb;
  localparam int DIRECTED_CMDS = 4 * 4 * 3;  // Ops x amounts x operands
  localparam int RANDOM_CMDS   = 200;
  localparam int FULL_ACCEPTS  = `SHIFT_QUEUE_DEPTH + 1;  // Queue plus stage register
  localparam int FULL_OFFERS   = FULL_ACCEPTS + 5;
  localparam int TOTAL_CMDS    = DIRECTED_CMDS + 2 * RANDOM_CMDS + FULL_ACCEPTS;
  localparam int TIMEOUT_CYCLES = 4 * TOTAL_CMDS + 200;

  logic       clk;
  logic       rst_n;
  shift_cmd_t cmd;
  logic       cmd_valid;
  logic       cmd_ready;
  shift_rsp_t rsp;
  logic       rsp_valid;
  logic       rsp_ready;

  shift_rsp_t  exp_q [$];     // Expected responses in command order
  shift_rsp_t  expected_rsp;
  bp_mode_e    bp_mode;
  logic [31:0] stim_state;
  logic [31:0] bp_state;
  string       test_name;
  int          errors;
  int          err_base;
  int          rsp_count;
  int          rsp_base;
  int          tests_run;
  int          tests_failed;
  int          cycle_count;

  shift_unit_clock u_clock (.clk(clk));

  shift_unit_top UUT (
    .clk       (clk),
    .rst_n     (rst_n),
    .cmd       (cmd),
    .cmd_valid (cmd_valid),
    .cmd_ready (cmd_ready),
    .rsp       (rsp),
    .rsp_valid (rsp_valid),
    .rsp_ready (rsp_ready)
  );

  function automatic logic [31:0] lcg_step(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  // Bit-by-bit model of the shift rules
  function automatic shift_rsp_t reference_rsp(input shift_cmd_t c);
    shift_rsp_t  r;
    shift_word_t w;
    logic        last_out;
    int          n;
    w        = c.operand;
    last_out = 1'b0;
    n        = int'(c.amount);
    if (c.op == SHIFT_SWAP) begin
      w = {c.operand[15:0], c.operand[31:16]};
    end else begin
      for (int i = 0; i < n; i++) begin
        last_out = w[0];  // Bit about to leave
        case (c.op)
          SHIFT_LSR: w = {1'b0, w[31:1]};
          SHIFT_ASR: w = {w[31], w[31:1]};
          default:   w = {w[0], w[31:1]};  // Rotate
        endcase
      end
    end
    r.result = w;
    r.zero   = (w == '0);
    r.carry  = last_out;
    return r;
  endfunction

  task automatic compare_word(input string what, input shift_word_t exp, input shift_word_t act);
    if (exp !== act) begin
      $display("Mismatch in %s (%s): expected %h actual %h", test_name, what, exp, act);
      errors++;
    end
  endtask

  task automatic compare_flag(input string what, input logic exp, input logic act);
    if (exp !== act) begin
      $display("Mismatch in %s (%s): expected %b actual %b", test_name, what, exp, act);
      errors++;
    end
  endtask

  task automatic compare_count(input string what, input int exp, input int act);
    if (exp != act) begin
      $display("Mismatch in %s (%s): expected %0d actual %0d", test_name, what, exp, act);
      errors++;
    end
  endtask

  task automatic make_random_cmd(output shift_cmd_t c);
    stim_state = lcg_step(stim_state);
    c.amount   = stim_state[31:27];  // Upper bits spread better
    c.op       = shift_op_e'(stim_state[26:25]);
    stim_state = lcg_step(stim_state);
    c.operand  = stim_state;
  endtask

  // Offers one command and holds it until the DUT takes it
  task automatic send_cmd(input shift_cmd_t c);
    bit done;
    done = 1'b0;
    while (!done) begin
      @(negedge clk);
      cmd       = c;
      cmd_valid = 1'b1;
      #1;
      if (cmd_ready) begin
        exp_q.push_back(reference_rsp(c));
        done = 1'b1;
      end
    end
  endtask

  task automatic start_test(input string name);
    test_name = name;
    err_base  = errors;
    rsp_base  = rsp_count;
  endtask

  task automatic drain_and_report(input int sent);
    int errs;
    while (exp_q.size() != 0) begin
      @(negedge clk);
      cmd_valid = 1'b0;
    end
    @(negedge clk);  // One idle cycle to catch a stray response
    cmd_valid = 1'b0;
    #2;
    compare_count("responses", sent, rsp_count - rsp_base);
    errs = errors - err_base;
    tests_run++;
    if (errs != 0) begin
      tests_failed++;
    end
    $display("Test %s finished: %0d commands, %0d errors", test_name, sent, errs);
  endtask

  // Response ready per back-pressure mode
  always @(negedge clk) begin
    case (bp_mode)
      BP_OPEN:   rsp_ready = 1'b1;
      BP_STALL:  rsp_ready = 1'b0;
      default: begin
        bp_state  = lcg_step(bp_state);
        rsp_ready = bp_state[31];
      end
    endcase
  end

  // Monitor checks the handshake that the next rising edge completes
  always @(negedge clk) begin
    #1;
    if (rst_n && rsp_valid && rsp_ready) begin
      if (exp_q.size() == 0) begin
        $display("Error in %s: response seen with no command outstanding", test_name);
        errors++;
      end else begin
        expected_rsp = exp_q.pop_front();
        compare_word("result", expected_rsp.result, rsp.result);
        compare_flag("zero", expected_rsp.zero, rsp.zero);
        compare_flag("carry", expected_rsp.carry, rsp.carry);
        rsp_count++;
      end
    end
  end

  always @(posedge clk) begin
    cycle_count++;
    if (cycle_count >= TIMEOUT_CYCLES) begin
      $display("Timeout: run did not finish within %0d cycles, %0d responses outstanding",
               TIMEOUT_CYCLES, exp_q.size());
      $display("Verification failed");
      $finish;
    end
  end

  initial begin
    shift_cmd_t c;
    shift_rsp_t held;
    bit         held_seen;
    bit         pending;
    int         accepted;
    rst_n        = 1'b0;
    cmd          = '0;
    cmd_valid    = 1'b0;
    rsp_ready    = 1'b1;
    bp_mode      = BP_OPEN;
    stim_state   = SEED;
    bp_state     = ~SEED;
    test_name    = "reset";
    errors       = 0;
    err_base     = 0;
    rsp_count    = 0;
    rsp_base     = 0;
    tests_run    = 0;
    tests_failed = 0;
    cycle_count  = 0;

    // Reset held low for 10 cycles
    start_test("reset");
    repeat (10) begin
      @(negedge clk);
      #1;
      compare_flag("rsp_valid in reset", 1'b0, rsp_valid);
      compare_flag("cmd_ready in reset", 1'b1, cmd_ready);
    end
    rst_n = 1'b1;
    @(negedge clk);
    #1;
    compare_flag("rsp_valid after reset", 1'b0, rsp_valid);
    compare_flag("cmd_ready after reset", 1'b1, cmd_ready);
    drain_and_report(0);

    start_test("directed");
    for (int k = 0; k < 4; k++) begin
      for (int a = 0; a < 4; a++) begin
        for (int o = 0; o < 3; o++) begin
          c.op      = shift_op_e'(2'(k));
          c.amount  = (a == 0) ? 5'd0 : (a == 1) ? 5'd1 : (a == 2) ? 5'd31 : 5'd13;
          c.operand = (o == 0) ? 32'h8765_4321 : (o == 1) ? 32'h0000_0000 : 32'h0000_0001;
          send_cmd(c);
        end
      end
    end
    drain_and_report(DIRECTED_CMDS);

    start_test("random_stream");
    repeat (RANDOM_CMDS) begin
      make_random_cmd(c);
      send_cmd(c);
    end
    drain_and_report(RANDOM_CMDS);

    start_test("random_backpressure");
    bp_mode = BP_RANDOM;
    repeat (RANDOM_CMDS) begin
      make_random_cmd(c);
      send_cmd(c);
    end
    drain_and_report(RANDOM_CMDS);

    // Full queue with a command offered every cycle and the output stalled
    start_test("full_queue");
    bp_mode   = BP_STALL;
    accepted  = 0;
    held      = '0;
    held_seen = 1'b0;
    pending   = 1'b0;
    for (int i = 0; i < FULL_OFFERS; i++) begin
      @(negedge clk);
      if (!pending) begin
        make_random_cmd(c);
        pending = 1'b1;
      end
      cmd       = c;
      cmd_valid = 1'b1;
      #1;
      if (cmd_ready) begin
        exp_q.push_back(reference_rsp(c));
        accepted++;
        pending = 1'b0;
      end
      if (rsp_valid && !held_seen) begin
        held      = exp_q[0];  // Oldest command sits in the stage
        held_seen = 1'b1;
      end
      if (held_seen) begin
        compare_flag("rsp_valid held", 1'b1, rsp_valid);
        compare_word("result held", held.result, rsp.result);
        compare_flag("zero held", held.zero, rsp.zero);
        compare_flag("carry held", held.carry, rsp.carry);
      end
    end
    @(negedge clk);
    cmd_valid = 1'b0;
    compare_count("accepted while stalled", FULL_ACCEPTS, accepted);
    bp_mode = BP_OPEN;  // Release the output
    drain_and_report(FULL_ACCEPTS);

    $display("Summary: %0d tests run, %0d failed, %0d errors, %0d responses checked",
             tests_run, tests_failed, errors, rsp_count);
    if (errors == 0) begin
      $display("Verification passed");
    end else begin
      $display("Verification failed");
    end
    $finish;
  end

endmodule

// ==== sources.f ====
+incdir+include
logic/shift_unit_pkg.sv
logic/shift_cmd_queue.sv
logic/shift_stage.sv
logic/shift_unit_top.sv
bench/shift_unit_clock.sv
bench/shift_unit_tb.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the shift unit simulation with Verilator

rm -rf obj_dir sim.log

verilator --binary --timing --top-module shift_unit_tb -f sources.f \
  -Mdir obj_dir -o shift_unit_sim \
  || { echo "Build failed"; exit 1; }

./obj_dir/shift_unit_sim > sim.log 2>&1
cat sim.log

grep -q "^Verification passed$" sim.log && { echo "Simulation PASS"; exit 0; } \
  || { echo "Simulation FAIL"; exit 1; }
